// File: flist.f
+incdir+.
rrag_pkg.sv
agu_if.sv
reg_scoreboard_file.sv
agu_lane.sv
rrag_issue.sv
rrag_top.sv
rrag_assertions.sv
tb_rrag.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rrag
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_rrag.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module tb_rrag;

    localparam logic [2:0] SEG0 = 3'd1;
    localparam logic [2:0] SEG1 = 3'd2;

    // One table row holds a writeback and an instruction for the same cycle
    typedef struct packed {
        logic                       wb_en;
        logic [2:0]                 wb_addr;
        logic [`RRAG_ADDR_W-1:0]    wb_data;
        logic [1:0]                 mem;
        logic [2:0]                 base;
        logic [2:0]                 index;
        logic [2:0]                 ptr;
        logic                       use_base;
        logic                       use_index;
        logic [1:0]                 scale;
        logic [`RRAG_ADDR_W-1:0]    disp;
        logic [1:0]                 size;
        logic                       addr32;
        logic                       dest_valid;
        logic [2:0]                 dest;
        logic                       hold;
        logic                       exp_stall;
    } row_t;

    logic                       clk, rst, hold, stall, out_valid;
    logic                       wb_en, wb_seg_en, in_valid, dest_valid;
    logic                       use_base, use_index, mem0_used, mem1_used, addr32;
    logic [2:0]                 wb_addr, wb_seg_addr, dest_addr, seg0_addr, seg1_addr;
    logic [2:0]                 base_addr, index_addr, ptr_addr;
    logic [1:0]                 scale, size;
    logic [`RRAG_SEG_W-1:0]     wb_seg_data;
    logic [`RRAG_ADDR_W-1:0]    wb_data, disp;
    logic [`RRAG_ADDR_W-1:0]    mem_addr0, mem_addr0_end, mem_addr1, mem_addr1_end;

    // Shadow state of the reference model
    row_t                       rows[$];
    logic [`RRAG_ADDR_W-1:0]    sh_gpr[8];
    logic [`RRAG_SEG_W-1:0]     sh_seg[8];
    logic [7:0]                 sh_pend;
    logic                       exp_ov;
    logic [`RRAG_ADDR_W-1:0]    exp_addr[4];
    int                         cycles;
    int                         limit;

    rrag_top i_dut (.*);

    bind rrag_top rrag_assertions i_assert (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .accept        (accept),
        .hold          (hold),
        .out_valid     (out_valid),
        .mem_addr0     (mem_addr0),
        .mem_addr0_end (mem_addr0_end),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end),
        .pending       (i_regfile.pending)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout, the run did not finish within %0d cycles", limit);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lin_addr(input logic [15:0] sbase,
                                             input logic [31:0] ofs, input logic a32);
        logic [31:0] o;
        o = a32 ? ofs : {16'h0000, ofs[15:0]};
        return {sbase, 16'h0000} + o;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_wb(input int addr, input logic [31:0] data);
        row_t r;
        r = rows.pop_back();
        r.wb_en   = 1'b1;
        r.wb_addr = 3'(addr);
        r.wb_data = data;
        rows.push_back(r);
    endtask

    task automatic wb_row(input int addr, input logic [31:0] data);
        row_t r;
        r = '0;
        rows.push_back(r);
        add_wb(addr, data);
    endtask

    task automatic ins_row(input int mem, base, index, ptr, ub, ui, sc, dsp, sz, a32,
                           input int dv, dest, hd, exp_stall);
        row_t r;
        r = '{1'b0, 3'd0, 32'd0, 2'(mem), 3'(base), 3'(index), 3'(ptr), 1'(ub), 1'(ui),
              2'(sc), 32'(dsp), 2'(sz), 1'(a32), 1'(dv), 3'(dest), 1'(hd), 1'(exp_stall)};
        rows.push_back(r);
    endtask

    // Segment writes follow the register writes with the upper half of the data
    task automatic drive_row(input row_t r);
        wb_en       = r.wb_en;
        wb_addr     = r.wb_addr;
        wb_data     = r.wb_data;
        wb_seg_en   = r.wb_en;
        wb_seg_addr = r.wb_addr;
        wb_seg_data = r.wb_data[31:16];
        in_valid    = |r.mem;
        mem0_used   = r.mem[0];
        mem1_used   = r.mem[1];
        base_addr   = r.base;
        index_addr  = r.index;
        ptr_addr    = r.ptr;
        use_base    = r.use_base;
        use_index   = r.use_index;
        scale       = r.scale;
        disp        = r.disp;
        size        = r.size;
        addr32      = r.addr32;
        dest_valid  = r.dest_valid;
        dest_addr   = r.dest;
        hold        = r.hold;
    endtask

    task automatic apply_row(input int n, input row_t r);
        logic           m_stall;
        logic           acc;
        logic [31:0]    ofs;
        drive_row(r);
        #40;
        m_stall = (r.mem[0] & r.use_base & sh_pend[r.base]) |
                  (r.mem[0] & r.use_index & sh_pend[r.index]) |
                  (r.mem[1] & sh_pend[r.ptr]) | (exp_ov & r.hold);
        if (m_stall !== r.exp_stall) begin
            $display("Row %0d expects stall %0b but the model gives %0b", n, r.exp_stall,
                     m_stall);
            $display("FAIL: see errors above");
            $fatal(1, "table error");
        end
        check_val("stall", 32'(stall), 32'(r.exp_stall));
        acc = (|r.mem) & ~m_stall;
        if (acc) begin
            ofs = r.disp;
            if (r.use_base) begin
                ofs = ofs + sh_gpr[r.base];
            end
            if (r.use_index) begin
                ofs = ofs + (sh_gpr[r.index] << r.scale);
            end
            exp_addr[0] = lin_addr(sh_seg[SEG0], ofs, r.addr32);
            exp_addr[1] = exp_addr[0] + (32'd1 << r.size) - 32'd1;
            exp_addr[2] = lin_addr(sh_seg[SEG1], sh_gpr[r.ptr], r.addr32);
            exp_addr[3] = exp_addr[2] + (32'd1 << r.size) - 32'd1;
            exp_ov = 1'b1;
        end else if (!(exp_ov && r.hold)) begin
            exp_ov = 1'b0;
        end
        @(posedge clk);
        if (r.wb_en) begin
            sh_gpr[r.wb_addr]  = r.wb_data;
            sh_seg[r.wb_addr]  = r.wb_data[31:16];
            sh_pend[r.wb_addr] = 1'b0;
        end
        // Set after clear so a new destination wins
        if (acc && r.dest_valid) begin
            sh_pend[r.dest] = 1'b1;
        end
        #5;
        check_val("out_valid", 32'(out_valid), 32'(exp_ov));
        if (exp_ov) begin
            check_val("mem_addr0", mem_addr0, exp_addr[0]);
            check_val("mem_addr0_end", mem_addr0_end, exp_addr[1]);
            check_val("mem_addr1", mem_addr1, exp_addr[2]);
            check_val("mem_addr1_end", mem_addr1_end, exp_addr[3]);
        end
    endtask

    initial begin
        row_t idle;
        row_t probe;
        void'($urandom(43));
        idle = '0;
        drive_row(idle);
        seg0_addr = SEG0;
        seg1_addr = SEG1;
        rst       = 1'b1;
        for (int k = 0; k < 8; k++) begin
            sh_gpr[k] = '0;
            sh_seg[k] = '0;
        end
        sh_pend = '0;
        exp_ov  = 1'b0;

        for (int k = 1; k < 8; k++) begin
            wb_row(k, $urandom);
        end
        // mem base idx ptr ub ui scale disp size a32 dv dest hold stall
        ins_row(3, 1, 2, 3, 1, 1, 0, 'h10, 2, 1, 0, 0, 0, 0);
        ins_row(3, 2, 3, 1, 1, 1, 1, -4, 0, 1, 0, 0, 0, 0);
        ins_row(3, 3, 7, 2, 1, 1, 2, 'h1234, 1, 1, 0, 0, 0, 0);
        ins_row(3, 7, 1, 7, 1, 1, 3, 0, 3, 1, 0, 0, 0, 0);
        ins_row(3, 1, 2, 3, 0, 1, 2, 'h40, 2, 1, 0, 0, 0, 0);
        ins_row(3, 1, 2, 3, 1, 0, 2, 'h40, 2, 1, 0, 0, 0, 0);
        // 16-bit offsets with one row per size
        ins_row(3, 1, 2, 3, 1, 1, 1, 'hfff0, 0, 0, 0, 0, 0, 0);
        ins_row(3, 2, 1, 4, 1, 1, 0, 'hff00, 1, 0, 0, 0, 0, 0);
        ins_row(3, 5, 6, 5, 1, 1, 3, 'h8000, 2, 0, 0, 0, 0, 0);
        ins_row(3, 7, 7, 6, 1, 0, 0, 'hfffe, 3, 0, 0, 0, 0, 0);
        // r4 pending then hold on a full and on an empty output
        ins_row(3, 1, 2, 3, 1, 1, 0, 8, 2, 1, 1, 4, 0, 0);
        ins_row(1, 4, 2, 3, 1, 1, 0, 8, 2, 1, 0, 0, 1, 1);
        ins_row(1, 4, 2, 3, 1, 1, 0, 8, 2, 1, 0, 0, 0, 1);
        add_wb(4, $urandom);
        ins_row(1, 4, 2, 3, 1, 1, 0, 8, 2, 1, 0, 0, 1, 0);
        ins_row(3, 5, 1, 2, 1, 1, 1, 'h77, 1, 1, 0, 0, 1, 1);
        ins_row(3, 5, 1, 2, 1, 1, 1, 'h77, 1, 1, 0, 0, 0, 0);
        // r6 pending but not really read
        ins_row(3, 1, 2, 3, 1, 1, 0, 0, 2, 1, 1, 6, 0, 0);
        ins_row(3, 6, 2, 3, 0, 1, 1, 0, 2, 1, 0, 0, 0, 0);
        ins_row(3, 1, 6, 3, 1, 0, 1, 0, 2, 1, 0, 0, 0, 0);
        ins_row(2, 6, 6, 3, 1, 1, 0, 0, 2, 1, 0, 0, 0, 0);
        ins_row(1, 1, 2, 6, 1, 1, 0, 0, 2, 1, 0, 0, 0, 0);
        ins_row(2, 1, 2, 6, 1, 1, 0, 0, 2, 1, 0, 0, 0, 1);
        add_wb(6, $urandom);
        ins_row(2, 1, 2, 6, 1, 1, 0, 0, 2, 1, 0, 0, 0, 0);
        limit = rows.size() * 4 + 50;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        // Lanes used and hold high, but nothing valid and nothing pending
        probe           = '0;
        probe.mem       = 2'b11;
        probe.base      = 3'd1;
        probe.index     = 3'd2;
        probe.ptr       = 3'd3;
        probe.use_base  = 1'b1;
        probe.use_index = 1'b1;
        probe.hold      = 1'b1;
        drive_row(probe);
        in_valid = 1'b0;
        #40;
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("stall", 32'(stall), 32'd0);
        @(posedge clk);
        #5;
        foreach (rows[i]) begin
            apply_row(i, rows[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: rrag_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module rrag_assertions (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  logic                        accept,
    input  logic                        hold,
    input  logic                        out_valid,
    input  logic [`RRAG_ADDR_W-1:0]     mem_addr0,
    input  logic [`RRAG_ADDR_W-1:0]     mem_addr0_end,
    input  logic [`RRAG_ADDR_W-1:0]     mem_addr1,
    input  logic [`RRAG_ADDR_W-1:0]     mem_addr1_end,
    input  logic [`RRAG_NUM_GPR-1:0]    pending
);

    // Held output keeps valid and data
    a_hold_keeps_data: assert property (@(posedge clk) disable iff (rst)
        (out_valid && hold) |=> (out_valid && $stable(mem_addr0) && $stable(mem_addr0_end)
                                 && $stable(mem_addr1) && $stable(mem_addr1_end)))
        else $error("output changed while held");

    // A stalled instruction leaves no result behind
    a_no_accept_in_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && !(out_valid && hold)) |=> !out_valid)
        else $error("instruction accepted during stall");

    // Scoreboard and output stage empty out of reset
    a_reset_clears: assert property (@(posedge clk)
        rst |=> (pending == '0 && !out_valid))
        else $error("pending bits or out_valid set after reset");

endmodule

`default_nettype wire

// File: rrag_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module rrag_top (
    input  logic                        clk,
    input  logic                        rst,

    // Writeback
    input  logic                        wb_en,
    input  logic [`RRAG_GPR_AW-1:0]     wb_addr,
    input  logic [`RRAG_ADDR_W-1:0]     wb_data,
    input  logic                        wb_seg_en,
    input  logic [`RRAG_SEG_AW-1:0]     wb_seg_addr,
    input  logic [`RRAG_SEG_W-1:0]      wb_seg_data,

    // Instruction from decode
    input  logic                        in_valid,
    input  logic                        dest_valid,
    input  logic [`RRAG_GPR_AW-1:0]     dest_addr,
    input  logic [`RRAG_GPR_AW-1:0]     base_addr,
    input  logic [`RRAG_GPR_AW-1:0]     index_addr,
    input  logic [`RRAG_GPR_AW-1:0]     ptr_addr,
    input  logic [`RRAG_SEG_AW-1:0]     seg0_addr,
    input  logic [`RRAG_SEG_AW-1:0]     seg1_addr,
    input  logic                        use_base,
    input  logic                        use_index,
    input  logic                        mem0_used,
    input  logic                        mem1_used,
    input  logic [`RRAG_SCALE_W-1:0]    scale,
    input  logic [`RRAG_ADDR_W-1:0]     disp,
    input  logic [1:0]                  size,
    input  logic                        addr32,
    output logic                        stall,

    // To the memory stage
    input  logic                        hold,
    output logic                        out_valid,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr0,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr0_end,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr1,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr1_end
);

    logic accept;

    agu_if lane_bus [0:`RRAG_NUM_LANES-1] ();

    reg_scoreboard_file i_regfile (
        .clk         (clk),
        .rst         (rst),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .wb_seg_en   (wb_seg_en),
        .wb_seg_addr (wb_seg_addr),
        .wb_seg_data (wb_seg_data),
        .accept      (accept),
        .dest_valid  (dest_valid),
        .dest_addr   (dest_addr),
        .base_addr   (base_addr),
        .index_addr  (index_addr),
        .ptr_addr    (ptr_addr),
        .seg0_addr   (seg0_addr),
        .seg1_addr   (seg1_addr),
        .use_base    (use_base),
        .use_index   (use_index),
        .mem0_used   (mem0_used),
        .mem1_used   (mem1_used),
        .scale       (scale),
        .disp        (disp),
        .size        (rrag_pkg::opsize_e'(size)),
        .addr32      (addr32),
        .lane        (lane_bus)
    );

    for (genvar i = 0; i < `RRAG_NUM_LANES; i++) begin : g_lane
        agu_lane i_lane (
            .io (lane_bus[i])
        );
    end

    rrag_issue i_issue (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .hold          (hold),
        .lane          (lane_bus),
        .stall         (stall),
        .accept        (accept),
        .out_valid     (out_valid),
        .mem_addr0     (mem_addr0),
        .mem_addr0_end (mem_addr0_end),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end)
    );

endmodule

`default_nettype wire

// File: rrag_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module rrag_issue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic                        hold,

    agu_if.sink                         lane [0:`RRAG_NUM_LANES-1],

    output logic                        stall,
    output logic                        accept,
    output logic                        out_valid,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr0,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr0_end,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr1,
    output logic [`RRAG_ADDR_W-1:0]     mem_addr1_end
);

    localparam int PAIR_W = 2 * `RRAG_ADDR_W;

    logic [`RRAG_NUM_LANES-1:0]                 lane_stall;
    logic [`RRAG_NUM_LANES-1:0][PAIR_W-1:0]     addr_d;
    logic [`RRAG_NUM_LANES-1:0][PAIR_W-1:0]     addr_q;
    logic                                       out_held;

    // Gather lane results
    for (genvar i = 0; i < `RRAG_NUM_LANES; i++) begin : g_gather
        assign lane_stall[i] = lane[i].res.stall;
        assign addr_d[i]     = {lane[i].res.start_addr, lane[i].res.end_addr};
    end

    assign out_held = out_valid & hold;

    // Stall on a register dependency or a blocked output stage
    assign stall  = (|lane_stall) | out_held;
    assign accept = in_valid & ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!out_held) begin
            out_valid <= accept;
        end
    end

    // Accept is never high while the output is held
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_d;
        end
    end

    assign mem_addr0     = addr_q[0][PAIR_W-1:`RRAG_ADDR_W];
    assign mem_addr0_end = addr_q[0][`RRAG_ADDR_W-1:0];
    assign mem_addr1     = addr_q[1][PAIR_W-1:`RRAG_ADDR_W];
    assign mem_addr1_end = addr_q[1][`RRAG_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: agu_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module agu_lane (
    agu_if.lane io
);

    localparam int OFS16_W = 16;
    localparam int LAST_W  = 3;

    logic [`RRAG_ADDR_W-1:0]    base_term;
    logic [`RRAG_ADDR_W-1:0]    index_term;
    logic [`RRAG_ADDR_W-1:0]    offset_full;
    logic [`RRAG_ADDR_W-1:0]    offset;
    logic [`RRAG_ADDR_W-1:0]    seg_lin;
    logic [`RRAG_ADDR_W-1:0]    start_addr;
    logic [LAST_W-1:0]          last_ofs;
    logic                       dep_stall;

    // Effective offset
    always_comb begin
        base_term   = io.req.use_base ? io.req.base : '0;
        index_term  = io.req.use_index ? (io.req.index << io.req.scale) : '0;
        offset_full = base_term + index_term + io.req.disp;
    end

    // 16-bit mode wraps the offset inside the segment
    assign offset = io.req.addr32 ? offset_full :
                    {{(`RRAG_ADDR_W-OFS16_W){1'b0}}, offset_full[OFS16_W-1:0]};

    // Segment base times 65536
    assign seg_lin    = {io.req.seg, {(`RRAG_ADDR_W-`RRAG_SEG_W){1'b0}}};
    assign start_addr = seg_lin + offset;

    // Size in bytes minus one
    always_comb begin
        case (io.req.size)
            rrag_pkg::OPSIZE_BYTE:  last_ofs = 3'd0;
            rrag_pkg::OPSIZE_WORD:  last_ofs = 3'd1;
            rrag_pkg::OPSIZE_DWORD: last_ofs = 3'd3;
            rrag_pkg::OPSIZE_QWORD: last_ofs = 3'd7;
            default:                last_ofs = 3'd0;
        endcase
    end

    // Only registers the lane actually reads can hold it up
    assign dep_stall = io.req.used &
                       ((io.req.use_base & io.req.base_pend) |
                        (io.req.use_index & io.req.index_pend));

    always_comb begin
        io.res.start_addr = start_addr;
        io.res.end_addr   = start_addr + {{(`RRAG_ADDR_W-LAST_W){1'b0}}, last_ofs};
        io.res.stall      = dep_stall;
    end

endmodule

`default_nettype wire

// File: reg_scoreboard_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rrag_defines.svh"

module reg_scoreboard_file (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        wb_en,
    input  logic [`RRAG_GPR_AW-1:0]     wb_addr,
    input  logic [`RRAG_ADDR_W-1:0]     wb_data,
    input  logic                        wb_seg_en,
    input  logic [`RRAG_SEG_AW-1:0]     wb_seg_addr,
    input  logic [`RRAG_SEG_W-1:0]      wb_seg_data,

    input  logic                        accept,
    input  logic                        dest_valid,
    input  logic [`RRAG_GPR_AW-1:0]     dest_addr,

    input  logic [`RRAG_GPR_AW-1:0]     base_addr,
    input  logic [`RRAG_GPR_AW-1:0]     index_addr,
    input  logic [`RRAG_GPR_AW-1:0]     ptr_addr,
    input  logic [`RRAG_SEG_AW-1:0]     seg0_addr,
    input  logic [`RRAG_SEG_AW-1:0]     seg1_addr,
    input  logic                        use_base,
    input  logic                        use_index,
    input  logic                        mem0_used,
    input  logic                        mem1_used,
    input  logic [`RRAG_SCALE_W-1:0]    scale,
    input  logic [`RRAG_ADDR_W-1:0]     disp,
    input  rrag_pkg::opsize_e           size,
    input  logic                        addr32,

    agu_if.src                          lane [0:`RRAG_NUM_LANES-1]
);

    logic [`RRAG_ADDR_W-1:0]    gpr [`RRAG_NUM_GPR];
    logic [`RRAG_NUM_GPR-1:0]   pending;
    logic [`RRAG_SEG_W-1:0]     seg [`RRAG_NUM_SEG];

    rrag_pkg::lane_req_t        req0;
    rrag_pkg::lane_req_t        req1;

    // General registers and scoreboard
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `RRAG_NUM_GPR; k++) begin
                gpr[k] <= '0;
            end
            pending <= '0;
        end else begin
            if (wb_en) begin
                gpr[wb_addr]     <= wb_data;
                pending[wb_addr] <= 1'b0;
            end
            // New destination wins over a writeback to the same register
            if (accept && dest_valid) begin
                pending[dest_addr] <= 1'b1;
            end
        end
    end

    // Segment bases carry no scoreboard
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `RRAG_NUM_SEG; k++) begin
                seg[k] <= '0;
            end
        end else if (wb_seg_en) begin
            seg[wb_seg_addr] <= wb_seg_data;
        end
    end

    // Lane 0, full base + index*scale + disp form
    always_comb begin
        req0            = '0;
        req0.used       = mem0_used;
        req0.base       = gpr[base_addr];
        req0.index      = gpr[index_addr];
        req0.base_pend  = pending[base_addr];
        req0.index_pend = pending[index_addr];
        req0.use_base   = use_base;
        req0.use_index  = use_index;
        req0.scale      = scale;
        req0.disp       = disp;
        req0.seg        = seg[seg0_addr];
        req0.size       = size;
        req0.addr32     = addr32;
    end

    // Lane 1, pointer register only
    always_comb begin
        req1            = '0;
        req1.used       = mem1_used;
        req1.base       = gpr[ptr_addr];
        req1.base_pend  = pending[ptr_addr];
        req1.use_base   = 1'b1;
        req1.seg        = seg[seg1_addr];
        req1.size       = size;
        req1.addr32     = addr32;
    end

    assign lane[0].req = req0;
    assign lane[1].req = req1;

endmodule

`default_nettype wire

// File: agu_if.sv
`timescale 1ns/1ns
`default_nettype none

// One address lane, operands in and address range out
interface agu_if;

    rrag_pkg::lane_req_t req;
    rrag_pkg::lane_res_t res;

    // Register file side
    modport src (
        output req
    );

    // Address lane
    modport lane (
        input  req,
        output res
    );

    // Issue stage side
    modport sink (
        input res
    );

endinterface

`default_nettype wire

// File: rrag_pkg.sv
`default_nettype none

`include "rrag_defines.svh"

package rrag_pkg;

    // Operand size, 1, 2, 4 or 8 bytes
    typedef enum logic [1:0] {
        OPSIZE_BYTE  = 2'd0,
        OPSIZE_WORD  = 2'd1,
        OPSIZE_DWORD = 2'd2,
        OPSIZE_QWORD = 2'd3
    } opsize_e;

    // Operands for one address lane
    typedef struct packed {
        logic                       used;
        logic [`RRAG_ADDR_W-1:0]    base;
        logic [`RRAG_ADDR_W-1:0]    index;
        logic                       base_pend;
        logic                       index_pend;
        logic                       use_base;
        logic                       use_index;
        logic [`RRAG_SCALE_W-1:0]   scale;
        logic [`RRAG_ADDR_W-1:0]    disp;
        logic [`RRAG_SEG_W-1:0]     seg;
        opsize_e                    size;
        // 1 for 32-bit offsets, 0 for 16-bit
        logic                       addr32;
    } lane_req_t;

    // Linear address range and dependency stall of one lane
    typedef struct packed {
        logic [`RRAG_ADDR_W-1:0]    start_addr;
        logic [`RRAG_ADDR_W-1:0]    end_addr;
        logic                       stall;
    } lane_res_t;

endpackage

`default_nettype wire

// File: rrag_defines.svh
`ifndef RRAG_DEFINES_SVH
`define RRAG_DEFINES_SVH

// Register file sizes
`define RRAG_NUM_GPR 8
`define RRAG_NUM_SEG 8

// Register number widths
`define RRAG_GPR_AW 3
`define RRAG_SEG_AW 3

// Address lanes fed by the register file
`define RRAG_NUM_LANES 2

// Data and address width
`define RRAG_ADDR_W 32

// Segment base width, shifted up by 16 when added
`define RRAG_SEG_W 16

// Scale field, index shifted by 0 to 3
`define RRAG_SCALE_W 2

`endif
